/* src.f */
rv_pkg.sv
rv_alu.sv
rv_reg_file.sv
rv_control_unit.sv
rv_core.sv
tb_rv_core_sva.sv
tb_rv_core.sv

/* tb_rv_core.sv */
// Testbench for the RV32I execute core
// Runs a table of instructions through the req/ack handshake and checks each retire record
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  logic    clk;
  logic    rst_n_i;
  logic    instr_req_i;
  instr_t  instr_i;
  logic    instr_ack_o;
  retire_t retire_o;

  instr_t      row_instr[$];
  retire_t     row_want[$];
  int          err_cnt;
  int          pass_rows;
  int          fail_rows;
  int          cycle_cnt;
  int          cycle_limit;
  int unsigned lcg_state;

  rv_core u_dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .instr_req_i (instr_req_i),
    .instr_i     (instr_i),
    .instr_ack_o (instr_ack_o),
    .retire_o    (retire_o)
  );

  always #20 clk = ~clk;

  // Watchdog on the total run length
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the DUT did not finish the handshakes within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Instruction encoders per RV32I format
  function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, REGREG};
  endfunction

  function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
  endfunction

  function automatic instr_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic instr_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic instr_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
  endfunction

  // Expected retire records
  function automatic retire_t reg_write(input reg_addr_t rd, input word_t val, input word_t npc);
    retire_t r;
    r         = '0;
    r.rd      = rd;
    r.wdata   = val;
    r.wen     = 1'b1;
    r.next_pc = npc;
    return r;
  endfunction

  function automatic retire_t pc_only(input word_t npc);
    retire_t r;
    r         = '0;
    r.next_pc = npc;
    return r;
  endfunction

  function automatic retire_t load_access(input word_t addr, input word_t npc);
    retire_t r;
    r          = pc_only(npc);
    r.mem_addr = addr;
    r.dren     = 1'b1;
    return r;
  endfunction

  function automatic retire_t store_access(input word_t addr, input word_t data,
                                           input word_t npc);
    retire_t r;
    r           = pc_only(npc);
    r.mem_addr  = addr;
    r.mem_wdata = data;
    r.dwen      = 1'b1;
    return r;
  endfunction

  // Flags in the order illegal, ecall, ebreak, halt
  function automatic retire_t sys_status(input word_t npc, input logic [3:0] flags);
    retire_t r;
    r         = pc_only(npc);
    r.illegal = flags[3];
    r.ecall   = flags[2];
    r.ebreak  = flags[1];
    r.halt    = flags[0];
    return r;
  endfunction

  task automatic add_row(input instr_t ins, input retire_t want);
    row_instr.push_back(ins);
    row_want.push_back(want);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
      err_cnt++;
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t want);
    if (got !== want) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
      err_cnt++;
    end
  endtask

  // Data and address fields only count where the record says they are used
  task automatic compare_retire(input retire_t want);
    check_flag("retire_o.wen", retire_o.wen, want.wen);
    check_flag("retire_o.dren", retire_o.dren, want.dren);
    check_flag("retire_o.dwen", retire_o.dwen, want.dwen);
    check_flag("retire_o.illegal", retire_o.illegal, want.illegal);
    check_flag("retire_o.ecall", retire_o.ecall, want.ecall);
    check_flag("retire_o.ebreak", retire_o.ebreak, want.ebreak);
    check_flag("retire_o.halt", retire_o.halt, want.halt);
    check_word("retire_o.next_pc", retire_o.next_pc, want.next_pc);
    if (want.wen) begin
      check_reg("retire_o.rd", retire_o.rd, want.rd);
      check_word("retire_o.wdata", retire_o.wdata, want.wdata);
    end
    if (want.dren || want.dwen) begin
      check_word("retire_o.mem_addr", retire_o.mem_addr, want.mem_addr);
    end
    if (want.dwen) begin
      check_word("retire_o.mem_wdata", retire_o.mem_wdata, want.mem_wdata);
    end
  endtask

  // Called on a falling edge with the ack low
  task automatic apply_row(input instr_t ins, input retire_t want);
    int unsigned hold;
    instr_i     = ins;
    instr_req_i = 1'b1;
    @(negedge clk);
    while (!instr_ack_o) @(negedge clk);
    compare_retire(want);
    // Random hold time before the request drops
    lcg_state = lcg_next(lcg_state);
    hold      = (lcg_state >> 16) % 4;
    repeat (hold) @(negedge clk);
    instr_req_i = 1'b0;
    @(negedge clk);
    while (instr_ack_o) @(negedge clk);
  endtask

  initial begin
    int errs_before;
    int assert_fails;
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    instr_req_i = 1'b0;
    instr_i     = '0;
    err_cnt     = 0;
    pass_rows   = 0;
    fail_rows   = 0;
    cycle_cnt   = 0;
    lcg_state   = 2;

    // ALU ops with x1 = 5 and x2 = -3
    add_row(i_type(12'h005, 5'd0, F3_ADD, 5'd1, IMMED), reg_write(5'd1, 32'h0000_0005, 32'h004));
    add_row(i_type(12'hffd, 5'd0, F3_ADD, 5'd2, IMMED), reg_write(5'd2, 32'hffff_fffd, 32'h008));
    add_row(r_type(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3), reg_write(5'd3, 32'h0000_0002, 32'h00c));
    add_row(r_type(7'h20, 5'd2, 5'd1, F3_ADD, 5'd4), reg_write(5'd4, 32'h0000_0008, 32'h010));
    add_row(r_type(7'h00, 5'd2, 5'd1, F3_XOR, 5'd5), reg_write(5'd5, 32'hffff_fff8, 32'h014));
    add_row(r_type(7'h00, 5'd2, 5'd1, F3_OR, 5'd6), reg_write(5'd6, 32'hffff_fffd, 32'h018));
    add_row(r_type(7'h00, 5'd2, 5'd1, F3_AND, 5'd7), reg_write(5'd7, 32'h0000_0005, 32'h01c));
    add_row(r_type(7'h00, 5'd1, 5'd1, F3_SLL, 5'd8), reg_write(5'd8, 32'h0000_00a0, 32'h020));
    add_row(r_type(7'h00, 5'd1, 5'd2, F3_SR, 5'd9), reg_write(5'd9, 32'h07ff_ffff, 32'h024));
    add_row(r_type(7'h20, 5'd1, 5'd2, F3_SR, 5'd10), reg_write(5'd10, 32'hffff_ffff, 32'h028));
    add_row(r_type(7'h00, 5'd1, 5'd2, F3_SLT, 5'd11), reg_write(5'd11, 32'h0000_0001, 32'h02c));
    add_row(r_type(7'h00, 5'd1, 5'd2, F3_SLTU, 5'd12), reg_write(5'd12, 32'h0, 32'h030));
    add_row(i_type(12'h401, 5'd2, F3_SR, 5'd13, IMMED), reg_write(5'd13, 32'hffff_fffe, 32'h034));
    add_row(i_type(12'hfff, 5'd1, F3_SLT, 5'd14, IMMED), reg_write(5'd14, 32'h0, 32'h038));
    // Upper immediates and jumps
    add_row(u_type(20'h12345, 5'd15, LUI), reg_write(5'd15, 32'h1234_5000, 32'h03c));
    add_row(u_type(20'h00001, 5'd16, AUIPC), reg_write(5'd16, 32'h0000_103c, 32'h040));
    add_row(j_type(21'h00000c, 5'd17), reg_write(5'd17, 32'h0000_0044, 32'h04c));
    add_row(i_type(12'h020, 5'd1, 3'b000, 5'd18, JALR), reg_write(5'd18, 32'h0000_0050, 32'h024));
    // Branches taken then not taken
    add_row(b_type(13'h0010, 5'd1, 5'd1, F3_BEQ), pc_only(32'h034));
    add_row(b_type(13'h0010, 5'd2, 5'd1, F3_BEQ), pc_only(32'h038));
    add_row(b_type(13'h0008, 5'd2, 5'd1, F3_BNE), pc_only(32'h040));
    add_row(b_type(13'h0008, 5'd1, 5'd1, F3_BNE), pc_only(32'h044));
    add_row(b_type(13'h1ff8, 5'd1, 5'd2, F3_BLT), pc_only(32'h03c));
    add_row(b_type(13'h1ff8, 5'd2, 5'd1, F3_BLT), pc_only(32'h040));
    add_row(b_type(13'h0014, 5'd2, 5'd1, F3_BGE), pc_only(32'h054));
    add_row(b_type(13'h0014, 5'd1, 5'd2, F3_BGE), pc_only(32'h058));
    add_row(b_type(13'h0100, 5'd2, 5'd1, F3_BLTU), pc_only(32'h158));
    add_row(b_type(13'h0100, 5'd1, 5'd2, F3_BLTU), pc_only(32'h15c));
    add_row(b_type(13'h1ff0, 5'd1, 5'd2, F3_BGEU), pc_only(32'h14c));
    add_row(b_type(13'h1ff0, 5'd2, 5'd1, F3_BGEU), pc_only(32'h150));
    // Memory ops and the x0 write
    add_row(i_type(12'h008, 5'd1, 3'b010, 5'd20, LOAD), load_access(32'h0000_000d, 32'h154));
    add_row(s_type(12'hffc, 5'd4, 5'd1, 3'b010), store_access(32'h1, 32'h8, 32'h158));
    add_row(i_type(12'h007, 5'd1, F3_ADD, 5'd0, IMMED), reg_write(5'd0, 32'h0000_000c, 32'h15c));
    add_row(r_type(7'h00, 5'd0, 5'd1, F3_ADD, 5'd21), reg_write(5'd21, 32'h0000_0005, 32'h160));
    add_row(s_type(12'h000, 5'd0, 5'd1, 3'b010), store_access(32'h5, 32'h0, 32'h164));
    // Illegal opcode, ECALL, EBREAK and both halt words
    add_row(32'hffff_ffff, sys_status(32'h168, 4'b1000));
    add_row(32'h0000_0073, sys_status(32'h16c, 4'b0100));
    add_row(32'h0010_0073, sys_status(32'h170, 4'b0010));
    add_row(32'h7800_d073, sys_status(32'h174, 4'b0001));
    add_row(32'h780e_1073, sys_status(32'h178, 4'b0001));
    add_row(i_type(12'hfff, 5'd21, F3_ADD, 5'd22, IMMED), reg_write(5'd22, 32'h4, 32'h17c));

    cycle_limit = 10 * row_instr.size() + 100;

    repeat (4) @(negedge clk);
    rst_n_i = 1'b1;
    check_flag("instr_ack_o after reset", instr_ack_o, 1'b0);
    compare_retire(pc_only(RESET_PC));

    for (int i = 0; i < row_instr.size(); i++) begin
      errs_before = err_cnt;
      apply_row(row_instr[i], row_want[i]);
      if (err_cnt == errs_before) begin
        pass_rows++;
        $display("PASS row %0d instr 0x%h", i, row_instr[i]);
      end else begin
        fail_rows++;
        $display("FAIL row %0d instr 0x%h", i, row_instr[i]);
      end
    end

    assert_fails = u_dut.u_sva.fail_cnt;
    $display("Rows passed %0d, rows failed %0d, mismatches %0d, assertion failures %0d",
             pass_rows, fail_rows, err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_rv_core_sva.sv */
// Handshake and reset assertions for the execute core
// Bound into rv_core
`default_nettype none

module rv_core_sva (
  input logic            clk,
  input logic            rst_n_i,
  input logic            instr_req_i,
  input logic            instr_ack_o,
  input rv_pkg::retire_t retire_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Assertion failures so far
  int fail_cnt = 0;

  // Ack and all retire flags clear once reset is seen
  property reset_clears;
    @(posedge clk) !rst_n_i |=> (!instr_ack_o && !retire_o.wen && !retire_o.dren &&
                                 !retire_o.dwen && !retire_o.illegal && !retire_o.ecall &&
                                 !retire_o.ebreak && !retire_o.halt);
  endproperty

  // Accept edge, EXEC edge, then ack seen
  property ack_latency;
    @(posedge clk) disable iff (!rst_n_i)
      $rose(instr_req_i) |-> !instr_ack_o ##1 !instr_ack_o ##1 instr_ack_o;
  endproperty

  property ack_held;
    @(posedge clk) disable iff (!rst_n_i)
      (instr_ack_o && instr_req_i) |=> instr_ack_o;
  endproperty

  property retire_stable;
    @(posedge clk) disable iff (!rst_n_i)
      instr_ack_o ##1 instr_ack_o |-> $stable(retire_o);
  endproperty

  a_reset_clears: assert property (reset_clears)
    else begin
      fail_cnt++;
      $error("ack or retire flag set after reset");
    end

  a_ack_latency: assert property (ack_latency)
    else begin
      fail_cnt++;
      $error("ack not raised 2 edges after accept");
    end

  a_ack_held: assert property (ack_held)
    else begin
      fail_cnt++;
      $error("ack dropped while request high");
    end

  a_retire_stable: assert property (retire_stable)
    else begin
      fail_cnt++;
      $error("retire record changed under ack");
    end

endmodule

bind rv_core rv_core_sva u_sva (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .instr_req_i (instr_req_i),
  .instr_ack_o (instr_ack_o),
  .retire_o    (retire_o)
);

`default_nettype wire

/* rv_core.sv */
// RV32I execute core top level
// Takes one instruction per req/ack handshake, executes it, presents a retire record
`default_nettype none

module rv_core (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            instr_req_i,
  input  rv_pkg::instr_t  instr_i,
  output logic            instr_ack_o,
  output rv_pkg::retire_t retire_o
);
  import rv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    ACK
  } state_t;

  state_t  state_q;
  instr_t  instr_q;
  word_t   pc_q;
  logic    ack_q;
  retire_t retire_q;

  ctrl_t   ctrl;
  word_t   rdata1;
  word_t   rdata2;
  word_t   alu_a;
  word_t   alu_b;
  word_t   alu_result;
  word_t   pc_plus4;
  word_t   pc_plus_imm;
  word_t   next_pc;
  word_t   wdata;
  logic    cmp_cond;
  logic    branch_taken;
  logic    rf_wen;

  rv_control_unit u_decode (
    .instr_i (instr_q),
    .ctrl_o  (ctrl)
  );

  // Writes only land in the EXEC cycle
  assign rf_wen = (state_q == EXEC) && ctrl.wen;

  rv_reg_file u_regs (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .rs1_i    (ctrl.rs1),
    .rs2_i    (ctrl.rs2),
    .rd_i     (ctrl.rd),
    .wdata_i  (wdata),
    .wen_i    (rf_wen),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  assign alu_a = ctrl.alu_a_pc  ? pc_q     : rdata1;
  assign alu_b = ctrl.alu_b_imm ? ctrl.imm : rdata2;

  rv_alu u_alu (
    .op_i     (ctrl.alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  // Branch compare on the raw register values
  always_comb begin
    case (ctrl.branch_f3)
      F3_BEQ:  cmp_cond = (rdata1 == rdata2);
      F3_BNE:  cmp_cond = (rdata1 != rdata2);
      F3_BLT:  cmp_cond = ($signed(rdata1) < $signed(rdata2));
      F3_BGE:  cmp_cond = ($signed(rdata1) >= $signed(rdata2));
      F3_BLTU: cmp_cond = (rdata1 < rdata2);
      F3_BGEU: cmp_cond = (rdata1 >= rdata2);
      default: cmp_cond = 1'b0;
    endcase
  end

  assign branch_taken = ctrl.branch && cmp_cond;
  assign pc_plus4     = pc_q + 32'd4;
  assign pc_plus_imm  = pc_q + ctrl.imm;

  always_comb begin
    if (branch_taken || ctrl.jal) begin
      next_pc = pc_plus_imm;
    end else if (ctrl.jalr) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    case (ctrl.w_sel)
      W_SEL_PC4: wdata = pc_plus4;
      W_SEL_IMM: wdata = ctrl.imm;
      default:   wdata = alu_result;
    endcase
  end

  // Instruction holding register, loaded on an accepted request
  always_ff @(posedge clk) begin
    if (state_q == IDLE && instr_req_i) begin
      instr_q <= instr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      pc_q     <= RESET_PC;
      ack_q    <= 1'b0;
      retire_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (instr_req_i) begin
            state_q <= EXEC;
          end
        end
        EXEC: begin
          pc_q               <= next_pc;
          ack_q              <= 1'b1;
          retire_q.rd        <= ctrl.rd;
          retire_q.wdata     <= wdata;
          retire_q.wen       <= ctrl.wen;
          retire_q.next_pc   <= next_pc;
          retire_q.mem_addr  <= (ctrl.dren || ctrl.dwen) ? alu_result : '0;
          retire_q.mem_wdata <= ctrl.dwen ? rdata2 : '0;
          retire_q.dren      <= ctrl.dren;
          retire_q.dwen      <= ctrl.dwen;
          retire_q.illegal   <= ctrl.illegal;
          retire_q.ecall     <= ctrl.ecall;
          retire_q.ebreak    <= ctrl.ebreak;
          retire_q.halt      <= ctrl.halt;
          state_q            <= ACK;
        end
        ACK: begin
          // Hold the record until the requester lets go
          if (!instr_req_i) begin
            ack_q   <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign instr_ack_o = ack_q;
  assign retire_o    = retire_q;

endmodule

`default_nettype wire

/* rv_control_unit.sv */
// RV32I instruction decoder
// Splits the word into its fields and builds the control record and immediate
`default_nettype none

module rv_control_unit (
  input  rv_pkg::instr_t instr_i,
  output rv_pkg::ctrl_t  ctrl_o
);
  import rv_pkg::*;

  // Halt words recognized by the core
  localparam instr_t HALT_WORD_A = 32'h7800_d073;
  localparam instr_t HALT_WORD_B = 32'h780e_1073;

  opcode_t    opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_sb;
  word_t      imm_u;
  word_t      imm_uj;

  assign opcode = opcode_t'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];

  // Sign-extended immediates per format
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'h000};
  assign imm_uj = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

  always_comb begin
    ctrl_o           = '0;
    ctrl_o.rs1       = instr_i[19:15];
    ctrl_o.rs2       = instr_i[24:20];
    ctrl_o.rd        = instr_i[11:7];
    ctrl_o.branch_f3 = funct3;
    ctrl_o.alu_op    = ALU_ADD;
    ctrl_o.w_sel     = W_SEL_ALU;

    case (opcode)
      LUI: begin
        ctrl_o.imm   = imm_u;
        ctrl_o.wen   = 1'b1;
        ctrl_o.w_sel = W_SEL_IMM;
      end
      AUIPC: begin
        ctrl_o.imm       = imm_u;
        ctrl_o.wen       = 1'b1;
        ctrl_o.alu_a_pc  = 1'b1;
        ctrl_o.alu_b_imm = 1'b1;
      end
      JAL: begin
        ctrl_o.imm   = imm_uj;
        ctrl_o.wen   = 1'b1;
        ctrl_o.w_sel = W_SEL_PC4;
        ctrl_o.jal   = 1'b1;
      end
      JALR: begin
        ctrl_o.imm       = imm_i;
        ctrl_o.wen       = 1'b1;
        ctrl_o.w_sel     = W_SEL_PC4;
        ctrl_o.alu_b_imm = 1'b1;
        ctrl_o.jalr      = 1'b1;
      end
      BRANCH: begin
        ctrl_o.imm    = imm_sb;
        ctrl_o.branch = 1'b1;
      end
      LOAD: begin
        // No data memory behind the core, so no register write
        ctrl_o.imm       = imm_i;
        ctrl_o.alu_b_imm = 1'b1;
        ctrl_o.dren      = 1'b1;
      end
      STORE: begin
        ctrl_o.imm       = imm_s;
        ctrl_o.alu_b_imm = 1'b1;
        ctrl_o.dwen      = 1'b1;
      end
      IMMED, REGREG: begin
        ctrl_o.imm       = imm_i;
        ctrl_o.wen       = 1'b1;
        ctrl_o.alu_b_imm = (opcode == IMMED);
        case (funct3)
          F3_ADD:  ctrl_o.alu_op = (opcode == REGREG && instr_i[30]) ? ALU_SUB : ALU_ADD;
          F3_SLL:  ctrl_o.alu_op = ALU_SLL;
          F3_SLT:  ctrl_o.alu_op = ALU_SLT;
          F3_SLTU: ctrl_o.alu_op = ALU_SLTU;
          F3_XOR:  ctrl_o.alu_op = ALU_XOR;
          F3_SR:   ctrl_o.alu_op = instr_i[30] ? ALU_SRA : ALU_SRL;
          F3_OR:   ctrl_o.alu_op = ALU_OR;
          F3_AND:  ctrl_o.alu_op = ALU_AND;
          default: ctrl_o.alu_op = ALU_ADD;
        endcase
      end
      SYSTEM: begin
        ctrl_o.imm    = imm_i;
        ctrl_o.ecall  = (funct3 == F3_PRIV) && (instr_i[31:20] == PRIV_ECALL);
        ctrl_o.ebreak = (funct3 == F3_PRIV) && (instr_i[31:20] == PRIV_EBREAK);
      end
      FENCE: begin
        // Ordering is trivially met with one instruction in flight
        ctrl_o.imm = imm_i;
      end
      default: begin
        ctrl_o.illegal = 1'b1;
      end
    endcase

    ctrl_o.halt = (instr_i == HALT_WORD_A) || (instr_i == HALT_WORD_B);
  end

endmodule

`default_nettype wire

/* rv_reg_file.sv */
// RV32I integer register file
// 31 writable registers, x0 reads as zero, two async reads and one sync write
`default_nettype none

module rv_reg_file (
  input  logic              clk,
  input  logic              rst_n_i,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  rv_pkg::word_t     wdata_i,
  input  logic              wen_i,
  output rv_pkg::word_t     rdata1_o,
  output rv_pkg::word_t     rdata2_o
);
  import rv_pkg::*;

  // No storage for x0
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  always_comb begin
    if (rs1_i == '0) begin
      rdata1_o = '0;
    end else begin
      rdata1_o = regs[rs1_i];
    end
    if (rs2_i == '0) begin
      rdata2_o = '0;
    end else begin
      rdata2_o = regs[rs2_i];
    end
  end

endmodule

`default_nettype wire

/* rv_alu.sv */
// RV32I integer ALU
// Add, subtract, shifts, logic ops and signed and unsigned set-less-than
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_t op_i,
  input  rv_pkg::word_t   a_i,
  input  rv_pkg::word_t   b_i,
  output rv_pkg::word_t   result_o
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Only the low five bits of b count for shifts
  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = {31'b0, lt_signed};
      ALU_SLTU: result_o = {31'b0, lt_unsigned};
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      default:  result_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

/* rv_pkg.sv */
// RV32I execute subsystem shared definitions
// Widths, opcode and ALU encodings, funct3 groups, control and retire records
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] instr_t;

  // Major opcodes in instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011,
    SYSTEM = 7'b1110011,
    FENCE  = 7'b0001111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  // funct3 for IMMED and REGREG
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Privileged SYSTEM encodings live in imm[11:0]
  localparam logic [2:0]  F3_PRIV     = 3'b000;
  localparam logic [11:0] PRIV_ECALL  = 12'h000;
  localparam logic [11:0] PRIV_EBREAK = 12'h001;

  // Writeback source
  localparam logic [1:0] W_SEL_ALU = 2'd0;
  localparam logic [1:0] W_SEL_PC4 = 2'd1;
  localparam logic [1:0] W_SEL_IMM = 2'd2;

  localparam word_t RESET_PC = 32'h0000_0000;

  typedef struct packed {
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm;
    alu_op_t    alu_op;
    logic       alu_a_pc;
    logic       alu_b_imm;
    logic       wen;
    logic [1:0] w_sel;
    logic       branch;
    logic [2:0] branch_f3;
    logic       jal;
    logic       jalr;
    logic       dren;
    logic       dwen;
    logic       illegal;
    logic       ecall;
    logic       ebreak;
    logic       halt;
  } ctrl_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     wdata;
    logic      wen;
    word_t     next_pc;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      dren;
    logic      dwen;
    logic      illegal;
    logic      ecall;
    logic      ebreak;
    logic      halt;
  } retire_t;

endpackage

`default_nettype wire
